// ==== Bender.yml ====
package:
  name: exu_stage

sources:
  - include_dirs:
      - source
    files:
      - source/exu_op_pkg.sv
      - source/exu_mem_pkg.sv
      - source/exu_alu.sv
      - source/exu_branch.sv
      - source/exu_agu.sv
      - source/exu_stage.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/tb_exu_stage.sv

// ==== list.f ====
+incdir+source
+incdir+test
source/exu_op_pkg.sv
source/exu_mem_pkg.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_agu.sv
source/exu_stage.sv
test/tb_exu_stage.sv

// ==== source/exu_agu.sv ====
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_agu
    import exu_op_pkg::*;
    import exu_mem_pkg::*;
(
    input  mem_op_e                 op,
    input  logic [`EXU_XLEN-1:0]    src1,
    input  logic [`EXU_XLEN-1:0]    src2,
    input  logic [`EXU_XLEN-1:0]    imm,
    output sram_bank_e              bank,
    output logic [`EXU_SRAM_AW-1:0] offset
);

    eff_addr_u eff_addr;
    logic      is_load;
    logic      is_store;

    assign is_load  = op inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu};
    assign is_store = op inside {mem_sb, mem_sh, mem_sw};

    // loads take the offset on src2, stores on imm
    assign eff_addr.raw = src1 + (is_store ? imm : src2);

    always_comb begin
        if (is_load || is_store) begin
            bank   = eff_addr.fields.bank;
            offset = eff_addr.fields.offset;
        end else begin
            bank   = bank_none;
            offset = '0;
        end
    end

endmodule

// ==== source/exu_alu.sv ====
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_alu
    import exu_op_pkg::*;
(
    input  alu_op_e              op,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] src2,
    input  logic [`EXU_XLEN-1:0] pc,
    output logic [`EXU_XLEN-1:0] result
);

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign shamt       = src2[`EXU_SHAMT_W-1:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            alu_add:   result = src1 + src2;
            alu_sub:   result = src1 - src2;
            alu_slt:   result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
            alu_sltu:  result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
            alu_xor:   result = src1 ^ src2;
            alu_or:    result = src1 | src2;
            alu_and:   result = src1 & src2;
            alu_sll:   result = src1 << shamt;
            alu_srl:   result = src1 >> shamt;
            alu_sra:   result = $unsigned($signed(src1) >>> shamt);
            // upper immediate already placed by the decoder
            alu_lui:   result = src2;
            alu_auipc: result = pc + src2;
            // return address for jal/jalr
            alu_link:  result = pc + `EXU_XLEN'd4;
            default:   result = '0;
        endcase
    end

endmodule

// ==== source/exu_branch.sv ====
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_branch
    import exu_op_pkg::*;
(
    input  br_op_e                op,
    input  logic [`EXU_XLEN-1:0]  src1,
    input  logic [`EXU_XLEN-1:0]  src2,
    input  logic [`EXU_XLEN-1:0]  imm,
    input  logic [`EXU_XLEN-1:0]  pc,
    output logic                  taken,
    output logic [`EXU_PC_AW-1:0] target
);

    logic [`EXU_XLEN-1:0] target_full;

    always_comb begin
        case (op)
            br_beq:          taken = src1 == src2;
            br_bne:          taken = src1 != src2;
            br_blt:          taken = $signed(src1) < $signed(src2);
            br_bge:          taken = $signed(src1) >= $signed(src2);
            br_bltu:         taken = src1 < src2;
            br_bgeu:         taken = src1 >= src2;
            br_jal, br_jalr: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            // jal offset arrives on src2
            br_jal:  target_full = pc + src2;
            br_jalr: target_full = src1 + src2;
            default: target_full = pc + imm;
        endcase
    end

    assign target = target_full[`EXU_PC_AW-1:0];

endmodule

// ==== source/exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// data path
`define EXU_XLEN     32
`define EXU_REG_AW   5
`define EXU_SHAMT_W  5

// only the low pc bits go back to fetch
`define EXU_PC_AW    12

// sram address split
`define EXU_SRAM_AW  13
`define EXU_BANK_LSB 13

`endif

// ==== source/exu_mem_pkg.sv ====
`include "exu_macros.svh"

package exu_mem_pkg;
    import exu_op_pkg::*;

    typedef enum logic [1:0] {
        bank_iram = 2'b00,
        bank_oram = 2'b01,
        bank_wram = 2'b10,
        bank_none = 2'b11
    } sram_bank_e;

    // adder output vs. the sram view of the same word
    typedef union packed {
        logic [`EXU_XLEN-1:0] raw;
        struct packed {
            logic [`EXU_XLEN-`EXU_BANK_LSB-3:0] upper;
            sram_bank_e                          bank;
            logic [`EXU_SRAM_AW-1:0]             offset;
        } fields;
    } eff_addr_u;

    typedef struct packed {
        mem_op_e                 mem_op;
        logic                    wb_vld;
        logic [`EXU_REG_AW-1:0]  wb_addr;
        logic [`EXU_XLEN-1:0]    wb_data;
        logic [`EXU_XLEN-1:0]    st_data;
        sram_bank_e              bank;
        logic [`EXU_SRAM_AW-1:0] offset;
    } exu_mem_req_t;

endpackage

// ==== source/exu_op_pkg.sv ====
`include "exu_macros.svh"

package exu_op_pkg;

    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_auipc,
        alu_link
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } br_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lh,
        mem_lw,
        mem_lbu,
        mem_lhu,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_e;

    // one decoded instruction from the decoder
    typedef struct packed {
        alu_op_e                alu_op;
        br_op_e                 br_op;
        mem_op_e                mem_op;
        logic [`EXU_XLEN-1:0]   src1;
        logic [`EXU_XLEN-1:0]   src2;
        logic [`EXU_XLEN-1:0]   imm;
        logic [`EXU_XLEN-1:0]   pc;
        logic                   wb_vld;
        logic [`EXU_REG_AW-1:0] wb_addr;
    } exu_issue_t;

    typedef struct packed {
        logic                   vld;
        logic                   is_load;
        logic [`EXU_REG_AW-1:0] addr;
        logic [`EXU_XLEN-1:0]   data;
    } exu_wb_t;

endpackage

// ==== source/exu_stage.sv ====
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_stage
    import exu_op_pkg::*;
    import exu_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  exu_issue_t            issue,
    input  logic                  issue_vld,
    output logic                  issue_rdy,
    output exu_wb_t               wb,
    output logic                  redirect_vld,
    output logic [`EXU_PC_AW-1:0] redirect_addr,
    output logic                  mem_vld,
    output exu_mem_req_t          mem_req,
    input  logic                  mem_rdy
);

    logic                    xfer;
    logic                    accept;
    logic                    is_cond_br;
    logic                    mem_load;
    logic                    br_taken;
    logic [`EXU_PC_AW-1:0]   br_target;
    logic [`EXU_XLEN-1:0]    alu_result;
    sram_bank_e              agu_bank;
    logic [`EXU_SRAM_AW-1:0] agu_offset;
    exu_mem_req_t            mem_req_d;

    exu_alu u_alu (
        .op     (issue.alu_op),
        .src1   (issue.src1),
        .src2   (issue.src2),
        .pc     (issue.pc),
        .result (alu_result)
    );

    exu_branch u_branch (
        .op     (issue.br_op),
        .src1   (issue.src1),
        .src2   (issue.src2),
        .imm    (issue.imm),
        .pc     (issue.pc),
        .taken  (br_taken),
        .target (br_target)
    );

    exu_agu u_agu (
        .op     (issue.mem_op),
        .src1   (issue.src1),
        .src2   (issue.src2),
        .imm    (issue.imm),
        .bank   (agu_bank),
        .offset (agu_offset)
    );

    assign issue_rdy  = mem_rdy;
    assign xfer       = issue_vld & issue_rdy;
    // the slot right behind a redirect is flushed
    assign accept     = xfer & ~redirect_vld;
    assign is_cond_br = issue.br_op inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
    assign mem_load   = accept & ~is_cond_br;

    always_comb begin
        wb.vld     = accept & issue.wb_vld;
        wb.is_load = issue.mem_op inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu};
        wb.addr    = issue.wb_addr;
        wb.data    = alu_result;
    end

    always_comb begin
        mem_req_d.mem_op  = issue.mem_op;
        mem_req_d.wb_vld  = issue.wb_vld;
        mem_req_d.wb_addr = issue.wb_addr;
        mem_req_d.wb_data = alu_result;
        mem_req_d.st_data = issue.src2;
        mem_req_d.bank    = agu_bank;
        mem_req_d.offset  = agu_offset;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            redirect_vld <= 1'b0;
            mem_vld      <= 1'b0;
        end else begin
            redirect_vld <= accept & br_taken;
            mem_vld      <= mem_load | (mem_vld & ~mem_rdy);
        end
    end

    // mem_load needs mem_rdy, so the request holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            redirect_addr <= br_target;
        end
        if (mem_load) begin
            mem_req <= mem_req_d;
        end
    end

    a_redirect_single: assert property (
        @(posedge clk) disable iff (!arst_n) redirect_vld |=> !redirect_vld
    ) else $error("redirect_vld high two cycles in a row");

    a_mem_req_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_vld && !mem_rdy |=> mem_vld && $stable(mem_req)
    ) else $error("mem_req changed while stalled");

endmodule

// ==== test/exu_model.svh ====
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

function automatic logic [`EXU_XLEN-1:0] model_alu(alu_op_e op, logic [`EXU_XLEN-1:0] a,
        logic [`EXU_XLEN-1:0] b, logic [`EXU_XLEN-1:0] pc);
    logic [2*`EXU_XLEN-1:0] ext;
    logic [`EXU_XLEN-1:0]   bias;
    bias = 32'h8000_0000;
    // sign-extend to double width, then a plain shift gives sra
    ext = {{`EXU_XLEN{a[`EXU_XLEN-1]}}, a} >> b[4:0];
    case (op)
        alu_add:   return a + b;
        alu_sub:   return a + ~b + 1;
        alu_slt:   return ((a ^ bias) < (b ^ bias)) ? 1 : 0;
        alu_sltu:  return (a < b) ? 1 : 0;
        alu_xor:   return a ^ b;
        alu_or:    return a | b;
        alu_and:   return a & b;
        alu_sll:   return a << b[4:0];
        alu_srl:   return a >> b[4:0];
        alu_sra:   return ext[`EXU_XLEN-1:0];
        alu_lui:   return b;
        alu_auipc: return pc + b;
        alu_link:  return pc + 4;
        default:   return 0;
    endcase
endfunction

function automatic logic model_taken(br_op_e op, logic [`EXU_XLEN-1:0] a,
        logic [`EXU_XLEN-1:0] b);
    logic signed [`EXU_XLEN:0] sa;
    logic signed [`EXU_XLEN:0] sb;
    sa = {a[`EXU_XLEN-1], a};
    sb = {b[`EXU_XLEN-1], b};
    case (op)
        br_beq:  return a == b;
        br_bne:  return a != b;
        br_blt:  return sa < sb;
        br_bge:  return !(sa < sb);
        br_bltu: return a < b;
        br_bgeu: return !(a < b);
        br_jal:  return 1'b1;
        br_jalr: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [`EXU_PC_AW-1:0] model_target(br_op_e op, logic [`EXU_XLEN-1:0] a,
        logic [`EXU_XLEN-1:0] b, logic [`EXU_XLEN-1:0] imm, logic [`EXU_XLEN-1:0] pc);
    logic [`EXU_XLEN-1:0] t;
    if (op == br_jal)
        t = pc + b;
    else if (op == br_jalr)
        t = a + b;
    else
        t = pc + imm;
    return t[`EXU_PC_AW-1:0];
endfunction

function automatic logic model_is_load(mem_op_e op);
    return op == mem_lb || op == mem_lh || op == mem_lw || op == mem_lbu || op == mem_lhu;
endfunction

function automatic logic model_is_cond(br_op_e op);
    return op != br_none && op != br_jal && op != br_jalr;
endfunction

// {bank, offset} of the effective address, 11 and zero for no memory op
function automatic logic [14:0] model_bank_offset(mem_op_e op, logic [`EXU_XLEN-1:0] a,
        logic [`EXU_XLEN-1:0] b, logic [`EXU_XLEN-1:0] imm);
    logic [`EXU_XLEN-1:0] ea;
    if (op == mem_none)
        return {2'b11, 13'd0};
    ea = model_is_load(op) ? a + b : a + imm;
    return ea[`EXU_BANK_LSB+1:0];
endfunction

`endif

// ==== test/tb_exu_stage.sv ====
`timescale 1ns/100ps
`include "exu_macros.svh"

module tb_exu_stage
    import exu_op_pkg::*;
    import exu_mem_pkg::*;
();

    localparam int NUM_TESTS  = 2000;
    localparam int CLK_PERIOD = 100;

    logic                  clk;
    logic                  arst_n;
    exu_issue_t            issue;
    logic                  issue_vld;
    logic                  issue_rdy;
    exu_wb_t               wb;
    logic                  redirect_vld;
    logic [`EXU_PC_AW-1:0] redirect_addr;
    logic                  mem_vld;
    exu_mem_req_t          mem_req;
    logic                  mem_rdy;

    int                    mismatches;
    int                    other_errors;
    logic                  acc;
    logic                  squash;
    logic [`EXU_PC_AW-1:0] exp_target;
    exu_mem_req_t          exp_q[$];

    `include "exu_model.svh"

    exu_stage dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue         (issue),
        .issue_vld     (issue_vld),
        .issue_rdy     (issue_rdy),
        .wb            (wb),
        .redirect_vld  (redirect_vld),
        .redirect_addr (redirect_addr),
        .mem_vld       (mem_vld),
        .mem_req       (mem_req),
        .mem_rdy       (mem_rdy)
    );

    task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d total, %0d mismatches, %0d other",
                 mismatches + other_errors, mismatches, other_errors);
    endtask

    function automatic exu_issue_t random_issue();
        exu_issue_t ins;
        ins         = '0;
        ins.src1    = $urandom;
        ins.src2    = $urandom;
        ins.imm     = $urandom;
        ins.pc      = $urandom;
        ins.wb_addr = $urandom;
        case ($urandom % 4)
            0: begin
                ins.alu_op = alu_op_e'(1 + $urandom % 13);
                ins.wb_vld = 1'b1;
            end
            1: begin
                ins.br_op = br_op_e'(1 + $urandom % 8);
                if (ins.br_op == br_jal || ins.br_op == br_jalr) begin
                    ins.alu_op = alu_link;
                    ins.wb_vld = 1'b1;
                end
                // equal operands now and then so beq/bge take
                if ($urandom % 4 == 0)
                    ins.src2 = ins.src1;
            end
            2: begin
                ins.mem_op      = mem_op_e'(1 + $urandom % 5);
                ins.wb_vld      = 1'b1;
                ins.src1[14:13] = $urandom % 4;
                ins.src2        = $urandom % 256;
            end
            default: begin
                ins.mem_op      = mem_op_e'(6 + $urandom % 3);
                ins.src1[14:13] = $urandom % 4;
                ins.imm         = $urandom % 256;
            end
        endcase
        return ins;
    endfunction

    function automatic exu_mem_req_t expected_req(exu_issue_t ins);
        exu_mem_req_t r;
        logic [14:0]  bo;
        bo        = model_bank_offset(ins.mem_op, ins.src1, ins.src2, ins.imm);
        r.mem_op  = ins.mem_op;
        r.wb_vld  = ins.wb_vld;
        r.wb_addr = ins.wb_addr;
        r.wb_data = model_alu(ins.alu_op, ins.src1, ins.src2, ins.pc);
        r.st_data = ins.src2;
        r.bank    = sram_bank_e'(bo[14:13]);
        r.offset  = bo[12:0];
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * CLK_PERIOD * 20);
        other_errors++;
        $display("timeout: the test did not finish in time");
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    // sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (!arst_n) begin
            squash = 1'b0;
            exp_q.delete();
            check("mem_vld", mem_vld, 1'b0);
            check("redirect_vld", redirect_vld, 1'b0);
        end else begin
            acc = issue_vld && mem_rdy && !squash;
            check("issue_rdy", issue_rdy, mem_rdy);
            check("redirect_vld", redirect_vld, squash);
            if (squash)
                check("redirect_addr", redirect_addr, exp_target);
            check("wb.vld", wb.vld, acc && issue.wb_vld);
            if (acc)
                check("wb.is_load", wb.is_load, model_is_load(issue.mem_op));
            if (acc && issue.wb_vld) begin
                check("wb.data", wb.data, model_alu(issue.alu_op, issue.src1, issue.src2, issue.pc));
                check("wb.addr", wb.addr, issue.wb_addr);
            end
            check("mem_vld", mem_vld, exp_q.size() > 0);
            if (mem_vld && exp_q.size() > 0) begin
                check("mem_req", mem_req, exp_q[0]);
                if (mem_rdy)
                    void'(exp_q.pop_front());
            end
            if (acc && !model_is_cond(issue.br_op))
                exp_q.push_back(expected_req(issue));
            squash     = acc && model_taken(issue.br_op, issue.src1, issue.src2);
            exp_target = model_target(issue.br_op, issue.src1, issue.src2, issue.imm, issue.pc);
        end
    end

    initial begin
        mismatches   = 0;
        other_errors = 0;
        squash       = 1'b0;
        arst_n       = 1'b0;
        issue        = '0;
        issue_vld    = 1'b0;
        mem_rdy      = 1'b0;
        void'($urandom(32'hd19d01ef));
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (NUM_TESTS) begin
            @(posedge clk);
            issue     <= random_issue();
            issue_vld <= ($urandom % 4) != 0;
            mem_rdy   <= ($urandom % 4) != 0;
        end
        // drain the last request
        @(posedge clk);
        issue_vld <= 1'b0;
        mem_rdy   <= 1'b1;
        repeat (3) @(posedge clk);
        print_counts();
        if (mismatches + other_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
